// File: tb.f
verilog/read_path_pkg.sv
verilog/read_valid_predict.sv
verilog/read_latency_shift.sv
verilog/read_data_fifo.sv
verilog/read_datapath.sv
tests/read_datapath_checker.sv
tests/tb_read_datapath.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_read_datapath
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_read_datapath.sv
/* Testbench top for the read datapath: clock, reset, memory return model,
   calibration, read stimulus and run timeout */
`timescale 1ns/1ns

module tb_read_datapath
	import read_path_pkg::*;
();

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 5;
	// Beats are on the bus MEM_RETURN cycles after the edge sampling the request
	localparam int MEM_RETURN     = 6;
	localparam int CAL_INCREMENTS = MEM_RETURN - VFIFO_BASE_OFFSET - 1;
	localparam logic [DDIO_WIDTH-1:0] FILLER = 16'hA5A5;
	localparam int NUM_READS   = 40;
	localparam int MAX_GAP     = 12;
	localparam int SCHED_DEPTH = 64;
	// Three worst-case read spacings per read plus room for the calibrations
	localparam int TIMEOUT_CYCLES = 3 * NUM_READS * MAX_GAP + 60;

	logic                      pll_afi_clk = 1'b0;
	logic                      reset_n_afi_clk;
	afi_req_t                  afi_req;
	seq_ctrl_t                 seq_ctrl;
	logic [DDIO_WIDTH-1:0]     ddio_phy_dq;
	logic [AFI_DATA_WIDTH-1:0] afi_rdata;
	logic [AFI_DATA_WIDTH-1:0] phy_mux_read_fifo_q;
	phase_vec_t                afi_rdata_valid;
	int                        pending;
	int                        reads_checked;
	int                        mismatch_count;
	int                        error_count;
	int unsigned               cycle_cnt = 0;
	int                        seed = 22;
	// Beats waiting to be returned, indexed by the cycle they go out on
	logic [DDIO_WIDTH-1:0]     beat_sched [SCHED_DEPTH];

	read_datapath uut (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.afi_req_i             (afi_req),
		.seq_ctrl_i            (seq_ctrl),
		.ddio_phy_dq_i         (ddio_phy_dq),
		.afi_rdata_o           (afi_rdata),
		.afi_rdata_valid_o     (afi_rdata_valid),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q)
	);

	read_datapath_checker u_checker (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.afi_req_i             (afi_req),
		.seq_ctrl_i            (seq_ctrl),
		.ddio_phy_dq_i         (ddio_phy_dq),
		.afi_rdata_i           (afi_rdata),
		.afi_rdata_valid_i     (afi_rdata_valid),
		.phy_mux_read_fifo_q_i (phy_mux_read_fifo_q),
		.pending_o             (pending),
		.reads_checked_o       (reads_checked),
		.mismatch_count_o      (mismatch_count),
		.error_count_o         (error_count)
	);

	always #(CLK_PERIOD/2) pll_afi_clk = ~pll_afi_clk;

	always @(posedge pll_afi_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run still busy after %0d cycles with %0d reads pending",
				TIMEOUT_CYCLES, pending);
			$display("test failed");
			$finish;
		end
	end

	// Memory model returns scheduled beats and idles with the filler pattern
	always @(negedge pll_afi_clk) begin
		ddio_phy_dq = beat_sched[cycle_cnt % SCHED_DEPTH];
		beat_sched[cycle_cnt % SCHED_DEPTH] = FILLER;
	end

	task automatic idle(input int n);
		repeat (n) @(negedge pll_afi_clk);
	endtask

	// Two request cycles with both phases full, the first one owning the word
	task automatic issue_read();
		logic [DDIO_WIDTH-1:0] beat0;
		logic [DDIO_WIDTH-1:0] beat1;
		beat0 = DDIO_WIDTH'($random(seed));
		beat1 = DDIO_WIDTH'($random(seed));
		beat_sched[(cycle_cnt + 1 + MEM_RETURN) % SCHED_DEPTH] = beat0;
		beat_sched[(cycle_cnt + 2 + MEM_RETURN) % SCHED_DEPTH] = beat1;
		afi_req.rdata_en      = '1;
		afi_req.rdata_en_full = '1;
		idle(1);
		afi_req.rdata_en = '0;
		idle(1);
		afi_req = '0;
	endtask

	task automatic random_reads(input int count, input int min_gap);
		int gap;
		for (int i = 0; i < count; i++) begin
			gap = min_gap + int'($unsigned($random(seed)) % (MAX_GAP - min_gap + 1));
			issue_read();
			idle(gap - 2);
		end
	endtask

	// The checker's count of outstanding reads is stable on the rising edge
	task automatic wait_drained();
		while (pending != 0) begin
			@(posedge pll_afi_clk);
		end
		idle(4);
	endtask

	// ************************************************************
	// Calibration and test sequence
	// ************************************************************

	// Dropping memory-stable restarts every FIFO, then each group is trained
	task automatic calibrate(input int inc0, input int inc1, input int latency);
		int rounds;
		rounds = (inc0 > inc1) ? inc0 : inc1;
		seq_ctrl.reset_mem_stable = 1'b0;
		idle(3);
		seq_ctrl.reset_mem_stable = 1'b1;
		seq_ctrl.latency_count    = LAT_CNT_WIDTH'(latency);
		idle(4);
		for (int i = 0; i < rounds; i++) begin
			seq_ctrl.increment_vfifo[0] = (i < inc0);
			seq_ctrl.increment_vfifo[1] = (i < inc1);
			idle(1);
			seq_ctrl.increment_vfifo = '0;
			idle(1);
		end
		idle(4);
	endtask

	initial begin
		afi_req         = '0;
		seq_ctrl        = '0;
		ddio_phy_dq     = FILLER;
		reset_n_afi_clk = 1'b0;
		for (int i = 0; i < SCHED_DEPTH; i++) begin
			beat_sched[i] = FILLER;
		end
		idle(RESET_CYCLES);
		reset_n_afi_clk = 1'b1;
		idle(2);
		calibrate(CAL_INCREMENTS, CAL_INCREMENTS, 8);
		random_reads(12, 6);
		wait_drained();
		// Back to back, so several reads are in flight at once
		for (int i = 0; i < 6; i++) begin
			issue_read();
		end
		wait_drained();
		seq_ctrl.latency_count = LAT_CNT_WIDTH'(10);
		idle(2);
		random_reads(10, 6);
		wait_drained();
		// Group 0 FIFO reset while idle must not disturb later reads
		seq_ctrl.read_fifo_reset[0] = 1'b1;
		idle(3);
		seq_ctrl.read_fifo_reset[0] = 1'b0;
		idle(4);
		random_reads(6, 6);
		wait_drained();
		// Group 1 one increment short captures the filler ahead of its data
		calibrate(CAL_INCREMENTS, CAL_INCREMENTS - 1, 8);
		random_reads(6, 6);
		wait_drained();
		if (reads_checked != NUM_READS) begin
			$display("read count wrong: %0d reads issued but %0d returned",
				NUM_READS, reads_checked);
		end
		$display("reads checked %0d of %0d, mismatches %0d, other errors %0d",
			reads_checked, NUM_READS, mismatch_count, error_count);
		if (mismatch_count == 0 && error_count == 0 && reads_checked == NUM_READS) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: tests/read_datapath_checker.sv
/* Read datapath checker with the reference model of the AFI read words,
   the queue of expected reads, output comparison and error counts */
`timescale 1ns/1ns

module read_datapath_checker
	import read_path_pkg::*;
(
	input  logic                      pll_afi_clk,
	input  logic                      reset_n_afi_clk,
	input  afi_req_t                  afi_req_i,
	input  seq_ctrl_t                 seq_ctrl_i,
	input  logic [DDIO_WIDTH-1:0]     ddio_phy_dq_i,
	input  logic [AFI_DATA_WIDTH-1:0] afi_rdata_i,
	input  phase_vec_t                afi_rdata_valid_i,
	input  logic [AFI_DATA_WIDTH-1:0] phy_mux_read_fifo_q_i,
	output int                        pending_o,
	output int                        reads_checked_o,
	output int                        mismatch_count_o,
	output int                        error_count_o
);

	// Enough beat history to cover the longest latency the count can select
	localparam int unsigned HIST_DEPTH = 64;

	// One outstanding read, keyed by the edge that sampled its first request cycle
	typedef struct packed {
		logic [31:0]                 req_edge;
		logic [31:0]                 out_edge;
		phase_vec_t                  valid;
		logic [NUM_GROUPS-1:0][7:0]  delay;
	} exp_read_t;

	exp_read_t             exp_q [$];
	int unsigned           edge_cnt = 0;
	logic [DDIO_WIDTH-1:0] beat_hist [HIST_DEPTH];
	// Increment pulses seen per group since memory-stable last went high
	int unsigned           inc_count [NUM_GROUPS];
	// Inputs as the DUT saw them at the last rising edge
	afi_req_t              req_s;
	seq_ctrl_t             seq_s;
	logic [DDIO_WIDTH-1:0] beat_s;
	logic                  rst_n_s = 1'b0;

	// Builds both AFI orderings of one read from the beats each group captured
	// Each beat carries two slots of a group with the earlier slot in the low half
	function automatic void ref_read_words(
		input  logic [NUM_GROUPS-1:0][DDIO_WIDTH-1:0] first_beat,
		input  logic [NUM_GROUPS-1:0][DDIO_WIDTH-1:0] second_beat,
		output logic [AFI_DATA_WIDTH-1:0]             afi_word,
		output logic [AFI_DATA_WIDTH-1:0]             mux_word
	);
		logic [2*GROUP_WIDTH-1:0] lane;
		logic [GROUP_WIDTH-1:0]   slot;
		afi_word = '0;
		mux_word = '0;
		for (int g = 0; g < NUM_GROUPS; g++) begin
			for (int t = 0; t < SLOTS; t++) begin
				lane = (t < 2) ? first_beat[g][2*GROUP_WIDTH*g +: 2*GROUP_WIDTH]
					: second_beat[g][2*GROUP_WIDTH*g +: 2*GROUP_WIDTH];
				slot = lane[GROUP_WIDTH*(t%2) +: GROUP_WIDTH];
				// Controller side is slot-major, sequencer side is group-major
				afi_word[MEM_DQ_WIDTH*t + GROUP_WIDTH*g +: GROUP_WIDTH] = slot;
				mux_word[SLOTS*GROUP_WIDTH*g + GROUP_WIDTH*t +: GROUP_WIDTH] = slot;
			end
		end
	endfunction

	// Inputs change on the falling edge, so they are captured on the rising one
	always @(posedge pll_afi_clk) begin
		edge_cnt = edge_cnt + 1;
		req_s    = afi_req_i;
		seq_s    = seq_ctrl_i;
		beat_s   = ddio_phy_dq_i;
		rst_n_s  = reset_n_afi_clk;
	end

	// ************************************************************
	// Expected reads and output comparison
	// ************************************************************

	always @(negedge pll_afi_clk) begin
		exp_read_t                             rd;
		logic [NUM_GROUPS-1:0][DDIO_WIDTH-1:0] first_beat;
		logic [NUM_GROUPS-1:0][DDIO_WIDTH-1:0] second_beat;
		logic [AFI_DATA_WIDTH-1:0]             exp_afi;
		logic [AFI_DATA_WIDTH-1:0]             exp_mux;
		phase_vec_t                            exp_valid;
		int unsigned                           cap;
		beat_hist[edge_cnt % HIST_DEPTH] = beat_s;
		if (rst_n_s && reset_n_afi_clk) begin
			for (int g = 0; g < NUM_GROUPS; g++) begin
				if (!seq_s.reset_mem_stable) begin
					inc_count[g] = 0;
				end else if (seq_s.increment_vfifo[g]) begin
					inc_count[g] = inc_count[g] + 1;
				end
			end
			// A token shows up base offset + 1 + increments after the sampling
			// edge, and the word leaves L + 4 cycles after its request cycle
			if (req_s.rdata_en != '0) begin
				rd.req_edge = edge_cnt;
				rd.out_edge = edge_cnt + seq_s.latency_count + 4;
				rd.valid    = req_s.rdata_en;
				for (int g = 0; g < NUM_GROUPS; g++) begin
					rd.delay[g] = 8'(VFIFO_BASE_OFFSET + 1 + inc_count[g]);
				end
				exp_q.push_back(rd);
			end
			while (exp_q.size() != 0 && exp_q[0].out_edge < edge_cnt) begin
				rd = exp_q.pop_front();
				error_count_o++;
				$display("ERROR time=%0t: read sampled at edge %0d never reached its output cycle",
					$time, rd.req_edge);
			end
			exp_valid = '0;
			if (exp_q.size() != 0 && exp_q[0].out_edge == edge_cnt) begin
				rd        = exp_q.pop_front();
				exp_valid = rd.valid;
				// Each group writes the beats present on the edge after its tokens
				for (int g = 0; g < NUM_GROUPS; g++) begin
					cap            = rd.req_edge + rd.delay[g] + 1;
					first_beat[g]  = beat_hist[cap % HIST_DEPTH];
					second_beat[g] = beat_hist[(cap + 1) % HIST_DEPTH];
				end
				ref_read_words(first_beat, second_beat, exp_afi, exp_mux);
				reads_checked_o++;
				if (afi_rdata_i !== exp_afi) begin
					mismatch_count_o++;
					$display("MISMATCH time=%0t afi_rdata_o expected=%h got=%h",
						$time, exp_afi, afi_rdata_i);
				end
				if (phy_mux_read_fifo_q_i !== exp_mux) begin
					mismatch_count_o++;
					$display("MISMATCH time=%0t phy_mux_read_fifo_q_o expected=%h got=%h",
						$time, exp_mux, phy_mux_read_fifo_q_i);
				end
			end
			// Valid must be low on every cycle that has no read due
			if (afi_rdata_valid_i !== exp_valid) begin
				mismatch_count_o++;
				$display("MISMATCH time=%0t afi_rdata_valid_o expected=%b got=%b",
					$time, exp_valid, afi_rdata_valid_i);
			end
		end
		pending_o = exp_q.size();
	end

endmodule

// File: verilog/read_datapath.sv
/* Half-rate QDR II read datapath top: per-group valid prediction and
   data FIFOs, latency selection, output registers and AFI remapping */
`timescale 1ns/1ns

module read_datapath
	import read_path_pkg::*;
(
	input  logic                      pll_afi_clk,
	input  logic                      reset_n_afi_clk,
	input  afi_req_t                  afi_req_i,
	input  seq_ctrl_t                 seq_ctrl_i,
	input  logic [DDIO_WIDTH-1:0]     ddio_phy_dq_i,
	output logic [AFI_DATA_WIDTH-1:0] afi_rdata_o,
	output phase_vec_t                afi_rdata_valid_o,
	output logic [AFI_DATA_WIDTH-1:0] phy_mux_read_fifo_q_o
);

	// Any phase of rdata_en_full makes a token for that cycle
	logic                               rdata_en_any;
	// Per-group capture strobes from valid prediction
	group_vec_t                         wren;
	// Per-phase read valid and the single FIFO read enable, both delayed
	// by the sequencer latency
	phase_vec_t                         read_valid;
	logic                               read_enable;
	// Groups whose data FIFO is out of reset
	group_vec_t                         group_live_q;
	phase_vec_t                         valid_all;
	phase_vec_t                         valid_q;
	group_word_t [NUM_GROUPS-1:0]       fifo_word;
	group_word_t [NUM_GROUPS-1:0]       p2c_word_q;

	assign rdata_en_any = |afi_req_i.rdata_en_full;

	// ************************************************************
	// Per-group valid prediction and data capture
	// ************************************************************

	// The DDIO beat is ordered by group, each group holding T1 over T0
	for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
		read_valid_predict u_vfifo (
			.pll_afi_clk        (pll_afi_clk),
			.reset_n_afi_clk    (reset_n_afi_clk),
			.token_i            (rdata_en_any),
			.reset_mem_stable_i (seq_ctrl_i.reset_mem_stable),
			.increment_i        (seq_ctrl_i.increment_vfifo[g]),
			.wren_o             (wren[g])
		);

		read_data_fifo u_dfifo (
			.pll_afi_clk        (pll_afi_clk),
			.reset_n_afi_clk    (reset_n_afi_clk),
			.reset_mem_stable_i (seq_ctrl_i.reset_mem_stable),
			.read_fifo_reset_i  (seq_ctrl_i.read_fifo_reset[g]),
			.wren_i             (wren[g]),
			.beat_i             (ddio_phy_dq_i[2*GROUP_WIDTH*g +: 2*GROUP_WIDTH]),
			.read_enable_i      (read_enable),
			.word_o             (fifo_word[g])
		);
	end

	// rdata_en marks the request cycle that owns an AFI word, while
	// rdata_en_full covers both beats and drives the FIFO read enable
	read_latency_shift #(
		.payload_t (phase_vec_t)
	) u_valid_shift (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.req_i           (afi_req_i.rdata_en),
		.latency_count_i (seq_ctrl_i.latency_count),
		.sel_o           (read_valid)
	);

	read_latency_shift #(
		.payload_t (logic)
	) u_enable_shift (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.req_i           (rdata_en_any),
		.latency_count_i (seq_ctrl_i.latency_count),
		.sel_o           (read_enable)
	);

	// ************************************************************
	// Read valid across groups
	// ************************************************************

	// Tracks the same registered reset as each group's data FIFO
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			group_live_q <= '0;
		end else begin
			group_live_q <= {NUM_GROUPS{seq_ctrl_i.reset_mem_stable}} &
				~seq_ctrl_i.read_fifo_reset;
		end
	end

	// A phase is valid only when every group reports it
	always_comb begin
		for (int p = 0; p < RATE_RATIO; p++) begin
			valid_all[p] = &(group_live_q & {NUM_GROUPS{read_valid[p]}});
		end
	end

	// Two stages line the valid up with the FIFO output and P2C register
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			valid_q           <= '0;
			afi_rdata_valid_o <= '0;
		end else begin
			valid_q           <= valid_all;
			afi_rdata_valid_o <= valid_q;
		end
	end

	// P2C register between the FIFO outputs and the AFI remap
	always_ff @(posedge pll_afi_clk) begin
		p2c_word_q <= fifo_word;
	end

	// afi_rdata is slot-major, group-minor for the controller
	// phy_mux_read_fifo_q is group-major, slot-minor for the sequencer
	for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_remap
		for (genvar t = 0; t < SLOTS; t++) begin : g_slot
			assign afi_rdata_o[MEM_DQ_WIDTH*t + GROUP_WIDTH*g +: GROUP_WIDTH] =
				p2c_word_q[g][GROUP_WIDTH*t +: GROUP_WIDTH];
			assign phy_mux_read_fifo_q_o[SLOTS*GROUP_WIDTH*g + GROUP_WIDTH*t +: GROUP_WIDTH] =
				p2c_word_q[g][GROUP_WIDTH*t +: GROUP_WIDTH];
		end
	end

endmodule

// File: verilog/read_data_fifo.sv
/* Read-data resynchronization FIFO for one group: packs two captured
   beats into one four-slot entry and returns it on read enable */
`timescale 1ns/1ns

module read_data_fifo
	import read_path_pkg::*;
(
	input  logic                     pll_afi_clk,
	input  logic                     reset_n_afi_clk,
	input  logic                     reset_mem_stable_i,
	input  logic                     read_fifo_reset_i,
	input  logic                     wren_i,
	input  logic [2*GROUP_WIDTH-1:0] beat_i,
	input  logic                     read_enable_i,
	output group_word_t              word_o
);

	// Local reset, low while the memory is unstable or the sequencer
	// resets this group's FIFO
	logic                             local_rst_n_q;
	// High while the first beat of a pair is waiting for its partner
	logic                             wr_half_q;
	// High on the second cycle of a read enable pair
	logic                             rd_half_q;
	logic [2*GROUP_WIDTH-1:0]         first_beat_q;
	group_word_t                      entry_mem_q [DFIFO_DEPTH];
	logic [$clog2(DFIFO_DEPTH)-1:0]   wr_ptr_q;
	logic [$clog2(DFIFO_DEPTH)-1:0]   rd_ptr_q;
	logic [$clog2(DFIFO_DEPTH):0]     count_q;
	logic                             push;
	logic                             pop;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			local_rst_n_q <= 1'b0;
		end else begin
			local_rst_n_q <= reset_mem_stable_i & ~read_fifo_reset_i;
		end
	end

	// An entry is pushed with the second beat of a pair
	assign push = local_rst_n_q & wren_i & wr_half_q;

	// Read enable follows rdata_en_full and so spans both cycles of a
	// read; the entry is taken on the first cycle of the pair
	assign pop = local_rst_n_q & read_enable_i & ~rd_half_q;

	// ************************************************************
	// Pointers, pairing and occupancy
	// ************************************************************

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			wr_half_q <= 1'b0;
			rd_half_q <= 1'b0;
			wr_ptr_q  <= '0;
			rd_ptr_q  <= '0;
			count_q   <= '0;
		end else if (!local_rst_n_q) begin
			// A local reset also realigns the beat and read pairing
			wr_half_q <= 1'b0;
			rd_half_q <= 1'b0;
			wr_ptr_q  <= '0;
			rd_ptr_q  <= '0;
			count_q   <= '0;
		end else begin
			if (wren_i) begin
				wr_half_q <= ~wr_half_q;
			end
			if (read_enable_i) begin
				rd_half_q <= ~rd_half_q;
			end
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// First beat fills T0/T1 and the second beat fills T2/T3
	always_ff @(posedge pll_afi_clk) begin
		if (wren_i && !wr_half_q) begin
			first_beat_q <= beat_i;
		end
		if (push) begin
			entry_mem_q[wr_ptr_q] <= {beat_i, first_beat_q};
		end
		if (pop) begin
			word_o <= entry_mem_q[rd_ptr_q];
		end
	end

	// The sequencer's latency must leave an entry in place by the time it is read
	a_no_pop_empty: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		pop |-> (count_q != '0)
	) else $error("Read data FIFO read while empty");

	// Reads must drain entries faster than captured beats arrive
	a_no_push_full: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		push |-> (count_q < ($clog2(DFIFO_DEPTH)+1)'(DFIFO_DEPTH))
	) else $error("Read data FIFO written while full");

endmodule

// File: verilog/read_latency_shift.sv
/* Read request delay line with a registered tap selected by the
   sequencer latency count and generic over the request payload */
`timescale 1ns/1ns

module read_latency_shift
	import read_path_pkg::*;
#(
	parameter type payload_t = logic
) (
	input  logic                     pll_afi_clk,
	input  logic                     reset_n_afi_clk,
	input  payload_t                 req_i,
	input  logic [LAT_CNT_WIDTH-1:0] latency_count_i,
	output payload_t                 sel_o
);

	// Request staged once ahead of the delay line
	payload_t req_q;
	// Tap i holds the request sampled i + 1 cycles ago
	payload_t delay_q [MAX_READ_LATENCY];

	// ************************************************************
	// Delay line and tap select
	// ************************************************************

	// Requests move one tap per cycle and the line starts out empty
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			req_q <= '0;
			for (int i = 0; i < MAX_READ_LATENCY; i++) begin
				delay_q[i] <= '0;
			end
		end else begin
			req_q      <= req_i;
			delay_q[0] <= req_q;
			for (int i = 1; i < MAX_READ_LATENCY; i++) begin
				delay_q[i] <= delay_q[i-1];
			end
		end
	end

	// Registered select, so a request leaves latency_count_i + 2 cycles
	// after the edge that sampled it
	// The sequencer only changes the count while no reads are pending
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			sel_o <= '0;
		end else begin
			sel_o <= delay_q[latency_count_i];
		end
	end

endmodule

// File: verilog/read_valid_predict.sv
/* Valid prediction for one read group: a token FIFO that turns read
   requests into data-capture write enables after a tunable delay */
`timescale 1ns/1ns

module read_valid_predict
	import read_path_pkg::*;
(
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic token_i,
	input  logic reset_mem_stable_i,
	input  logic increment_i,
	output logic wren_o
);

	// Registered copy of the sequencer's memory-stable level
	logic                        side_rst_n_q;
	// Request token, staged once before it is written
	logic                        token_q;
	// One token bit per FIFO entry
	logic [VFIFO_DEPTH-1:0]      token_mem_q;
	logic [VFIFO_DEPTH-1:0]      token_mem_d;
	logic [VFIFO_ADDR_WIDTH-1:0] wr_ptr_q;
	logic [VFIFO_ADDR_WIDTH-1:0] rd_ptr_q;

	// The FIFO side is held in reset until the memory is stable
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			side_rst_n_q <= 1'b0;
			token_q      <= 1'b0;
		end else begin
			side_rst_n_q <= reset_mem_stable_i;
			token_q      <= token_i;
		end
	end

	// The entry under the read pointer is cleared as it is read, so an
	// entry skipped by an increment never returns a stale token
	// A write to the same entry takes priority over the clear
	always_comb begin
		token_mem_d = token_mem_q;
		token_mem_d[rd_ptr_q] = 1'b0;
		token_mem_d[wr_ptr_q] = token_q;
	end

	// ************************************************************
	// Pointers and token read
	// ************************************************************

	// Both pointers advance every cycle, and the gap between them sets
	// the token delay of VFIFO_BASE_OFFSET + 1 plus one per increment
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			rd_ptr_q    <= '0;
			wr_ptr_q    <= VFIFO_ADDR_WIDTH'(VFIFO_BASE_OFFSET);
			token_mem_q <= '0;
			wren_o      <= 1'b0;
		end else if (!side_rst_n_q) begin
			// Write side restarts a fixed distance ahead of the read side
			rd_ptr_q    <= '0;
			wr_ptr_q    <= VFIFO_ADDR_WIDTH'(VFIFO_BASE_OFFSET);
			token_mem_q <= '0;
			wren_o      <= 1'b0;
		end else begin
			rd_ptr_q    <= rd_ptr_q + 1'b1;
			// An increment skips one entry and so adds one cycle of delay
			wr_ptr_q    <= increment_i ? (wr_ptr_q + 2'd2) : (wr_ptr_q + 2'd1);
			token_mem_q <= token_mem_d;
			wren_o      <= token_mem_q[rd_ptr_q];
		end
	end

	// Moving the write pointer under a live token would drop or double it
	a_no_increment_in_flight: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk || !side_rst_n_q)
		increment_i |-> (!token_q && (token_mem_q == '0))
	) else $error("VFIFO increment while tokens are in flight");

endmodule

// File: verilog/read_path_pkg.sv
/* Widths, depths, latencies and packed types shared by the
   half-rate QDR II read datapath and its testbench */
package read_path_pkg;

	// ************************************************************
	// Interface geometry
	// ************************************************************

	// Two read groups of four DQ bits each
	localparam int unsigned NUM_GROUPS     = 2;
	localparam int unsigned GROUP_WIDTH    = 4;
	// Half rate, so two AFI phases per pll_afi_clk cycle
	localparam int unsigned RATE_RATIO     = 2;
	localparam int unsigned MEM_DQ_WIDTH   = GROUP_WIDTH * NUM_GROUPS;
	// One DDIO beat carries two time slots of every DQ bit
	localparam int unsigned DDIO_WIDTH     = 2 * MEM_DQ_WIDTH;
	// Four time slots make one AFI word
	localparam int unsigned SLOTS          = 4;
	localparam int unsigned AFI_DATA_WIDTH = SLOTS * MEM_DQ_WIDTH;

	// ************************************************************
	// Latency and FIFO sizing
	// ************************************************************

	// Length of the request delay line and width of its tap select
	localparam int unsigned MAX_READ_LATENCY  = 16;
	localparam int unsigned LAT_CNT_WIDTH     = 4;
	// Token FIFO of the valid predictor
	localparam int unsigned VFIFO_DEPTH       = 16;
	localparam int unsigned VFIFO_ADDR_WIDTH  = 4;
	// Distance the write pointer runs ahead of the read pointer after reset
	localparam int unsigned VFIFO_BASE_OFFSET = 2;
	// Entries of each read-data resynchronization FIFO
	localparam int unsigned DFIFO_DEPTH       = 4;

	// One bit per AFI phase and one bit per read group
	typedef logic [RATE_RATIO-1:0] phase_vec_t;
	typedef logic [NUM_GROUPS-1:0] group_vec_t;

	// All four time slots of one group, slot 0 in the low bits
	typedef logic [SLOTS*GROUP_WIDTH-1:0] group_word_t;

	// Read requests from the controller
	typedef struct packed {
		phase_vec_t rdata_en;
		phase_vec_t rdata_en_full;
	} afi_req_t;

	// Calibration controls from the sequencer, all plain levels or strobes
	typedef struct packed {
		logic [LAT_CNT_WIDTH-1:0] latency_count;
		logic                     reset_mem_stable;
		group_vec_t               read_fifo_reset;
		group_vec_t               increment_vfifo;
	} seq_ctrl_t;

endpackage
